/* hdl/kd_patch_pkg.sv */
// Assumes patches of five unsigned 11-bit components packed with component 0 in the low bits
package kd_patch_pkg;

  // Width of one patch component in bits
  localparam int comp_width = 11;

  // Number of components that make up one patch
  localparam int num_comps = 5;

  // Full patch width as it arrives on the input port
  localparam int patch_width = comp_width * num_comps;

  // The same patch bits are read two ways
  // The ports carry the raw vector and the tree levels pick single components out of it
  typedef union packed {
    logic [patch_width-1:0] flat;  // Raw patch as driven on patch_in
    logic [num_comps-1:0][comp_width-1:0] comps;  // Component 0 sits in bits 10 down to 0
  } patch_u;

endpackage

/* hdl/kd_node_pkg.sv */
// Node words are 22 bits with only the low 14 bits decoded and bits 21 to 14 ignored
package kd_node_pkg;

  // Width of one stored node word as sent by the loader
  localparam int node_width = 22;

  // Split dimension field that names which patch component to test
  localparam int dim_lsb = 0;
  localparam int dim_width = 3;

  // Threshold field compared unsigned against the chosen component
  localparam int thr_lsb = 3;
  localparam int thr_width = 11;

  // Pulls the split dimension out of a node word
  function automatic logic [dim_width-1:0] node_dim(input logic [node_width-1:0] word);
    return word[dim_lsb +: dim_width];
  endfunction

  // Pulls the split threshold out of a node word
  function automatic logic [thr_width-1:0] node_thr(input logic [node_width-1:0] word);
    return word[thr_lsb +: thr_width];
  endfunction

endpackage

/* hdl/node_load_if.sv */
// One node write per cycle with no handshake and DEPTH must be at least 2 for the position field
`timescale 1ns/1ps
interface node_load_if
  import kd_node_pkg::*;
#(
  parameter int DEPTH = 7
) ();

  logic wen;  // High for one cycle per decoded node write
  logic [$clog2(DEPTH)-1:0] level;  // Tree level that owns the node
  logic [DEPTH-2:0] position;  // Node index inside that level
  logic [node_width-1:0] word;  // Node word to store

  // Loader side drives the decoded write
  modport src (
    output wen, level, position, word
  );

  // Every tree level listens and keeps only writes aimed at its own level
  modport dst (
    input wen, level, position, word
  );

endinterface

/* hdl/kd_node_loader.sv */
// Writes cannot be stalled and the counter only restarts at node 0 after a full tree or a reset
`timescale 1ns/1ps
module kd_node_loader
  import kd_node_pkg::*;
#(
  parameter int DEPTH = 7
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fsm_enable,     // Outside FSM opens the load window
  input  logic                  sender_enable,  // Sender marks a valid word
  input  logic [node_width-1:0] sender_data,
  node_load_if.src              load,
  output logic                  load_done       // Sticky until reset once a full tree is in
);

  localparam int lvl_w = $clog2(DEPTH);

  // Breadth-first index of the last internal node
  localparam logic [DEPTH-1:0] last_node = DEPTH'((1 << DEPTH) - 2);

  logic             accept;
  logic [DEPTH-1:0] wadr;       // Breadth-first index of the next node to write
  logic [DEPTH-1:0] node_num;   // One-based heap number of that node
  logic [lvl_w-1:0] dec_level;
  logic [DEPTH-1:0] pos_full;

  assign accept = fsm_enable && sender_enable;  // Both enables qualify a write
  assign node_num = wadr + 1'b1;  // Never overflows since wadr stops at last_node

  // The level is the position of the leading one in the heap number
  always_comb begin
    dec_level = '0;
    for (int b = 0; b < DEPTH; b++) begin
      if (node_num[b]) begin
        dec_level = lvl_w'(b);  // Highest set bit wins
      end
    end
  end

  // Clearing that leading one leaves the offset inside the level
  assign pos_full = node_num ^ (DEPTH'(1) << dec_level);

  // Control state for the counter, the strobe and the done flag
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wadr      <= '0;
      load.wen  <= 1'b0;
      load_done <= 1'b0;
    end else begin
      load.wen <= accept;  // Strobe follows the accepted write by one cycle
      if (accept) begin
        if (wadr == last_node) begin
          wadr      <= '0;    // Wrap so a new tree starts again at the root
          load_done <= 1'b1;
        end else begin
          wadr <= wadr + 1'b1;
        end
      end
    end
  end

  // Decoded write payload held alongside the strobe
  always_ff @(posedge clk) begin
    if (accept) begin
      load.level    <= dec_level;
      load.position <= pos_full[DEPTH-2:0];  // Top bit is always clear after the XOR
      load.word     <= sender_data;
    end
  end

endmodule

/* hdl/kd_level.sv */
// Node writes that land while patches pass through this level take effect on the very next compare
`timescale 1ns/1ps
module kd_level
  import kd_patch_pkg::*;
  import kd_node_pkg::*;
#(
  parameter int DEPTH = 7,
  parameter int LEVEL = 0
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  node_load_if.dst                               load,
  input  logic                                   in_valid,
  input  patch_u                                 in_patch,
  input  logic [((LEVEL > 0) ? LEVEL : 1)-1:0]   in_path,   // Node index within this level
  output logic                                   out_valid,
  output patch_u                                 out_patch,
  output logic [LEVEL:0]                         out_path   // Node index within the next level
);

  localparam int num_nodes = 2 ** LEVEL;  // Nodes held at this depth
  localparam int pw_in = (LEVEL > 0) ? LEVEL : 1;  // Level 0 still needs a one-bit path
  localparam int lvl_w = $clog2(DEPTH);

  logic [node_width-1:0] node_mem [num_nodes];
  logic                  hit;
  logic [pw_in-1:0]      wr_idx;
  logic [node_width-1:0] cur_node;
  logic [dim_width-1:0]  dim;
  logic [dim_width-1:0]  dim_sel;
  logic [thr_width-1:0]  thr;
  logic [comp_width-1:0] comp;
  logic                  go_right;
  logic [pw_in:0]        path_ext;

  // A broadcast write belongs here only when its level matches
  assign hit = load.wen && (load.level == lvl_w'(LEVEL));
  assign wr_idx = load.position[pw_in-1:0];  // Upper position bits are zero for this level

  // Node registers start cleared so an unloaded tree sends every patch right
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int n = 0; n < num_nodes; n++) begin
        node_mem[n] <= '0;
      end
    end else if (hit) begin
      node_mem[wr_idx] <= load.word;
    end
  end

  // Node on the path of the patch currently at this level
  assign cur_node = node_mem[in_path];
  assign dim = node_dim(cur_node);
  assign thr = node_thr(cur_node);

  // Dimensions past the last component fall back to component 0
  assign dim_sel = (dim < num_comps) ? dim : '0;
  assign comp = in_patch.comps[dim_sel];

  // Equal values go right just like larger ones
  assign go_right = (comp >= thr);

  // Child index is twice the parent plus the branch bit
  assign path_ext = {in_path, go_right};

  // Only the valid flag needs a reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // Patch and path advance one level with their valid
  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_patch <= in_patch;
      out_path  <= path_ext[LEVEL:0];  // At level 0 this is just the branch bit
    end
  end

endmodule

/* hdl/kd_search_top.sv */
// Load the whole tree and leave DEPTH+2 idle cycles before searching since nothing stalls the pipe
`timescale 1ns/1ps
module kd_search_top
  import kd_patch_pkg::*;
  import kd_node_pkg::*;
#(
  parameter int DEPTH = 7
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fsm_enable,
  input  logic                   sender_enable,
  input  logic [node_width-1:0]  sender_data,
  input  logic                   patch_valid,
  input  logic [patch_width-1:0] patch_in,
  output logic                   leaf_valid,
  output logic [DEPTH-1:0]       leaf_index,  // Leaf reached at the bottom of the tree
  output logic                   load_done
);

  // Stage i feeds level i and stage DEPTH is the finished result
  logic [DEPTH:0]   stage_valid;
  patch_u           stage_patch [DEPTH+1];
  logic [DEPTH-1:0] stage_path  [DEPTH+1];  // Zero-extended so every stage has one width

  // Single decoded write bus shared by all levels
  node_load_if #(.DEPTH(DEPTH)) load_bus ();

  kd_node_loader #(
    .DEPTH(DEPTH)
  ) u_loader (
    .clk           (clk),
    .rst_n         (rst_n),
    .fsm_enable    (fsm_enable),
    .sender_enable (sender_enable),
    .sender_data   (sender_data),
    .load          (load_bus.src),
    .load_done     (load_done)
  );

  // Every patch starts its walk at the root
  assign stage_valid[0] = patch_valid;
  assign stage_patch[0].flat = patch_in;
  assign stage_path[0] = '0;

  // One registered level per tree depth
  for (genvar i = 0; i < DEPTH; i++) begin : g_level
    localparam int pw_in = (i > 0) ? i : 1;

    logic [i:0] next_path;  // Path as this level produces it

    kd_level #(
      .DEPTH(DEPTH),
      .LEVEL(i)
    ) u_level (
      .clk       (clk),
      .rst_n     (rst_n),
      .load      (load_bus.dst),
      .in_valid  (stage_valid[i]),
      .in_patch  (stage_patch[i]),
      .in_path   (stage_path[i][pw_in-1:0]),
      .out_valid (stage_valid[i+1]),
      .out_patch (stage_patch[i+1]),
      .out_path  (next_path)
    );

    assign stage_path[i+1] = DEPTH'(next_path);  // Last level already fills all DEPTH bits
  end

  // The path out of the last level is the leaf index
  assign leaf_valid = stage_valid[DEPTH];
  assign leaf_index = stage_path[DEPTH];

endmodule

/* testbench/kd_search_tb.sv */
// Runs DEPTH 7 only and expects every tree to be fully loaded with idle cycles before any search
`timescale 1ns/1ps
module kd_search_tb
  import kd_patch_pkg::*;
  import kd_node_pkg::*;
();

  localparam int DEPTH = 7;
  localparam int num_nodes = 2 ** DEPTH - 1;  // Internal nodes in breadth-first order
  localparam int clk_period = 100;
  // Two loads with a possible ignored write per node, three search runs, drains and reset
  localparam int max_cycles = 4 * num_nodes + 16 + 200 * 4 + 100 + 100 * 4 + 8 * (2 * DEPTH + 8);
  localparam int timeout_ns = (max_cycles + 500) * clk_period;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   fsm_enable;
  logic                   sender_enable;
  logic [node_width-1:0]  sender_data;
  logic                   patch_valid;
  logic [patch_width-1:0] patch_in;
  logic                   leaf_valid;
  logic [DEPTH-1:0]       leaf_index;
  logic                   load_done;

  logic [node_width-1:0]  tree_model [num_nodes];  // Node words as the sender wrote them
  logic [DEPTH-1:0]       exp_q [$];  // Predicted leaves in send order
  logic [patch_width-1:0] patch_q [$];  // Matching patches for the error text
  time                    sent_q [$];  // Falling edge on which each patch was driven
  logic [31:0]            lfsr_state = 32'd93;
  int                     errors = 0;
  int                     checks = 0;

  kd_search_top #(.DEPTH(DEPTH)) DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .fsm_enable    (fsm_enable),
    .sender_enable (sender_enable),
    .sender_data   (sender_data),
    .patch_valid   (patch_valid),
    .patch_in      (patch_in),
    .leaf_valid    (leaf_valid),
    .leaf_index    (leaf_index),
    .load_done     (load_done)
  );

  initial begin : clock_gen
    forever #(clk_period / 2) clk = ~clk;
  end

  // Right-shifting Galois LFSR with a maximal-length 32-bit tap mask
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  // One LFSR step per bit, bits collected MSB first
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Walks the model tree from the root down to a leaf
  function automatic logic [DEPTH-1:0] ref_leaf(input logic [patch_width-1:0] p);
    int path;
    int idx;
    int dim;
    int thr;
    int comp;
    path = 0;
    for (int lv = 0; lv < DEPTH; lv++) begin
      idx = (1 << lv) - 1 + path;  // Breadth-first slot of the node on the path
      dim = int'(tree_model[idx][dim_lsb +: dim_width]);
      thr = int'(tree_model[idx][thr_lsb +: thr_width]);
      if (dim >= num_comps) dim = 0;  // Out-of-range dimensions test component 0
      comp = int'(p[dim * comp_width +: comp_width]);
      path = 2 * path + ((comp >= thr) ? 1 : 0);
    end
    return DEPTH'(path);
  endfunction

  // A write that one of the two enables must block
  task automatic write_ignored(input logic fsm, input logic snd);
    fsm_enable    = fsm;
    sender_enable = snd;
    sender_data   = node_width'(rand_bits(node_width));
    @(negedge clk);
    fsm_enable    = 1'b0;
    sender_enable = 1'b0;
  endtask

  task automatic write_node(input int k);
    logic [node_width-1:0] w;
    w = node_width'(rand_bits(node_width));
    tree_model[k] = w;  // Model tracks the breadth-first slot the loader should use
    fsm_enable    = 1'b1;
    sender_enable = 1'b1;
    sender_data   = w;
    @(negedge clk);
    fsm_enable    = 1'b0;
    sender_enable = 1'b0;
  endtask

  // Full tree with ignored writes mixed in at random, load_done watched throughout
  task automatic load_tree(input logic done_before);
    for (int k = 0; k < num_nodes; k++) begin
      if (rand_bits(1) == 64'd1) write_ignored(k[0], !k[0]);
      if (load_done !== done_before) begin
        $display("mismatch at %0t: load_done is %b before write %0d, expected %b",
                 $time, load_done, k, done_before);
        errors++;
      end
      write_node(k);
    end
    if (load_done !== 1'b1) begin
      $display("mismatch at %0t: load_done is %b after the last write, expected 1",
               $time, load_done);
      errors++;
    end
  endtask

  task automatic send_patch(input int gap);
    logic [patch_width-1:0] p;
    p = patch_width'(rand_bits(patch_width));
    exp_q.push_back(ref_leaf(p));
    patch_q.push_back(p);
    sent_q.push_back($time);
    patch_valid = 1'b1;
    patch_in    = p;
    @(negedge clk);
    patch_valid = 1'b0;
    repeat (gap) @(negedge clk);
  endtask

  // Waits for outstanding results with a bound, then leaves the pipe idle
  task automatic drain_results();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DEPTH + 4) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Error at %0t: %0d search results never came out", $time, exp_q.size());
      errors++;
      exp_q.delete();
      patch_q.delete();
      sent_q.delete();
    end
    repeat (DEPTH + 2) @(negedge clk);
  endtask

  // Outputs settle after the rising edge so they are read at the falling one
  always @(negedge clk) begin : compare_leaf
    logic [DEPTH-1:0]       exp;
    logic [patch_width-1:0] p;
    time                    t_sent;
    if (rst_n && leaf_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("Error at %0t: leaf_valid went high with no search outstanding", $time);
        errors++;
      end else begin
        exp = exp_q.pop_front();
        p = patch_q.pop_front();
        t_sent = sent_q.pop_front();
        checks++;
        if (leaf_index !== exp) begin
          $display("mismatch at %0t: patch %h reached leaf %0d, expected %0d",
                   $time, p, leaf_index, exp);
          errors++;
        end
        // Each of the DEPTH levels holds the patch for exactly one cycle
        if ($time != t_sent + DEPTH * clk_period) begin
          $display("mismatch at %0t: patch %h sent at %0t left the tree late or early",
                   $time, p, t_sent);
          errors++;
        end
      end
    end
  end

  initial begin : stimulus
    rst_n         = 1'b0;
    fsm_enable    = 1'b0;
    sender_enable = 1'b0;
    sender_data   = '0;
    patch_valid   = 1'b0;
    patch_in      = '0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    repeat (5) begin  // Quiet outputs after reset
      @(negedge clk);
      if (leaf_valid !== 1'b0 || load_done !== 1'b0) begin
        $display("mismatch at %0t: leaf_valid %b load_done %b after reset, expected 0 0",
                 $time, leaf_valid, load_done);
        errors++;
      end
    end
    for (int i = 0; i < 8; i++) write_ignored(i[0], !i[0]);
    load_tree(1'b0);
    repeat (DEPTH + 2) @(negedge clk);
    repeat (200) send_patch(int'(rand_bits(2)));  // Gaps of 0 to 3 cycles
    drain_results();
    repeat (100) send_patch(0);  // Back to back
    drain_results();
    load_tree(1'b1);  // Counter wrapped so this starts again at the root
    repeat (DEPTH + 2) @(negedge clk);
    repeat (100) send_patch(int'(rand_bits(2)));
    drain_results();
    if (checks != 400) begin
      $display("Error: %0d results were checked instead of 400", checks);
      errors++;
    end
    $display("Checked %0d results with %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin : watchdog
    #(timeout_ns);
    $display("Error: simulation ran past %0d ns without finishing", timeout_ns);
    $display("Test failures found");
    $finish;
  end

endmodule

/* project.f */
hdl/kd_patch_pkg.sv
hdl/kd_node_pkg.sv
hdl/node_load_if.sv
hdl/kd_node_loader.sv
hdl/kd_level.sv
hdl/kd_search_top.sv
testbench/kd_search_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module kd_search_tb \
  -f project.f -o kd_search_sim > build.log 2>&1 &&
  ./obj_dir/kd_search_sim > sim.log 2>&1 ||
  { echo "Build or simulation run failed"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
